// ==== Makefile ====
TOP = tb_wfd
SRCS = $(shell cat filelist.f)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
rtl/wfd_pkg.sv
rtl/chan_stream_if.sv
rtl/trigger_manager.sv
rtl/fill_num_fifo.sv
rtl/rx_arbiter.sv
rtl/data_transfer_manager.sv
rtl/wfd_top.sv
testbench/wfd_assert.sv
testbench/tb_wfd.sv

// ==== rtl/chan_stream_if.sv ====
// valid/ready/last stream carrying channel words from the rx arbiter into the data transfer manager
interface chan_stream_if import wfd_pkg::*; ();

    logic       tvalid;   // word on tdata is valid
    logic       tready;   // sink can take a word
    chan_word_t tdata;
    logic       tlast;    // last word of the channel packet

    // arbiter side
    modport source (
        output tvalid, tdata, tlast,
        input  tready
    );

    // data transfer manager side
    modport sink (
        input  tvalid, tdata, tlast,
        output tready
    );

endinterface

// ==== rtl/data_transfer_manager.sv ====
// asks each channel for its readout per fill and assembles header, data words and trailer for the daq link
module data_transfer_manager import wfd_pkg::*; (
    input  logic              clk125,
    input  logic              arst_n,
    // fill number fifo
    input  logic              fill_valid,
    input  fill_num_t         fill_num,
    output logic              fill_ready,
    // readout request to the channels
    output logic              req_valid,
    output logic [CHAN_W-1:0] req_chan,
    output fill_num_t         req_fill,
    input  logic              req_ready,
    // merged rx stream from the arbiter
    chan_stream_if.sink       s,
    input  logic [CHAN_W-1:0] grant_chan,
    // amc13 daq link words
    output logic              daq_valid,
    output logic              daq_header,
    output logic              daq_trailer,
    output daq_word_t         daq_data,
    input  logic              daq_ready
);

    dtm_state_t           state;
    fill_num_t            cur_fill;     // fill being read out
    logic [CHAN_W-1:0]    chan_idx;     // channel being requested / collected
    logic [DAQ_CNT_W-1:0] word_cnt;     // data words in this event so far
    logic                 out_free;     // output register can take a word
    logic                 rx_xfer;
    logic                 hdr_load;
    logic                 trl_load;
    logic                 last_chan;

    assign out_free  = !daq_valid || daq_ready;
    assign last_chan = (chan_idx == CHAN_W'(NUM_CHAN - 1));

    assign fill_ready = (state == DTM_IDLE);

    // request held steady until the channel side takes it
    assign req_valid = (state == DTM_REQUEST);
    assign req_chan  = chan_idx;
    assign req_fill  = cur_fill;

    // rx only moves when the daq side moves, so a stall stops both
    assign s.tready = (state == DTM_COLLECT) && daq_ready;
    assign rx_xfer  = s.tvalid && s.tready;

    assign hdr_load = (state == DTM_HEADER) && out_free;
    assign trl_load = (state == DTM_TRAILER) && out_free;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state       <= DTM_IDLE;
            cur_fill    <= '0;
            chan_idx    <= '0;
            word_cnt    <= '0;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else begin
            if (daq_ready) daq_valid <= 1'b0;    // word taken, unless reloaded below

            case (state)
                DTM_IDLE: begin
                    if (fill_valid) begin
                        cur_fill <= fill_num;
                        chan_idx <= '0;           // channel 0 always goes first
                        word_cnt <= '0;
                        state    <= DTM_HEADER;
                    end
                end

                DTM_HEADER: begin
                    if (hdr_load) begin
                        daq_valid   <= 1'b1;
                        daq_header  <= 1'b1;
                        daq_trailer <= 1'b0;
                        state       <= DTM_REQUEST;
                    end
                end

                DTM_REQUEST: begin
                    if (req_ready) state <= DTM_COLLECT;
                end

                DTM_COLLECT: begin
                    if (rx_xfer) begin
                        daq_valid   <= 1'b1;
                        daq_header  <= 1'b0;
                        daq_trailer <= 1'b0;
                        word_cnt    <= word_cnt + 1'b1;
                        if (s.tlast) begin
                            if (last_chan) begin
                                state <= DTM_TRAILER;
                            end else begin
                                chan_idx <= chan_idx + 1'b1;
                                state    <= DTM_REQUEST;   // next channel in order
                            end
                        end
                    end
                end

                DTM_TRAILER: begin
                    if (trl_load) begin
                        daq_valid   <= 1'b1;
                        daq_header  <= 1'b0;
                        daq_trailer <= 1'b1;
                        state       <= DTM_IDLE;          // event closed
                    end
                end

                default: state <= DTM_IDLE;
            endcase
        end
    end

    // event word payload, only written when the output register is free
    always_ff @(posedge clk125) begin
        if (hdr_load) begin
            daq_data <= {DAQ_HDR_TAG, 32'd0, cur_fill};
        end else if (rx_xfer) begin
            daq_data <= {24'd0, 8'(grant_chan), s.tdata};  // chan number in 39:32
        end else if (trl_load) begin
            daq_data <= {DAQ_TRL_TAG, 24'd0, word_cnt};
        end
    end

endmodule

// ==== rtl/fill_num_fifo.sv ====
// small synchronous fifo of fill numbers between trigger manager and data transfer manager
module fill_num_fifo import wfd_pkg::*; (
    input  logic      clk125,
    input  logic      arst_n,
    // write side
    input  logic      in_valid,
    input  fill_num_t in_data,
    output logic      in_ready,
    // read side
    output logic      out_valid,
    output fill_num_t out_data,
    input  logic      out_ready
);

    fill_num_t             mem [FILL_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;     // one extra bit to tell full from empty
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != (FIFO_PTR_W+1)'(FILL_FIFO_DEPTH));   // refuse when full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];   // head entry, shows up the cycle after the push

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // storage
    always_ff @(posedge clk125) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap by themselves since the depth is a power of two
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // idle, or push and pop together
            endcase
        end
    end

endmodule

// ==== rtl/rx_arbiter.sv ====
// round-robin merge of the channel rx streams, grant kept until the packet's last word moves
module rx_arbiter import wfd_pkg::*; (
    input  logic                  clk125,
    input  logic                  arst_n,
    // channel side
    input  logic [NUM_CHAN-1:0]   chan_tvalid,
    input  chan_word_t [NUM_CHAN-1:0] chan_tdata,
    input  logic [NUM_CHAN-1:0]   chan_tlast,
    output logic [NUM_CHAN-1:0]   chan_tready,
    // granted channel number, tags the data words downstream
    output logic [CHAN_W-1:0]     grant_chan,
    chan_stream_if.source         m
);

    logic [CHAN_W-1:0] grant;       // current or most recent owner
    logic              locked;      // a packet is in flight
    logic [CHAN_W-1:0] next_grant;
    logic              found;
    int                idx;

    // search starts one past the last owner
    always_comb begin
        next_grant = grant;
        found      = 1'b0;
        idx        = 0;
        for (int i = 1; i <= NUM_CHAN; i++) begin
            idx = (int'(grant) + i) % NUM_CHAN;
            if (!found && chan_tvalid[idx]) begin
                next_grant = CHAN_W'(idx);
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            grant  <= CHAN_W'(NUM_CHAN - 1);  // so channel 0 wins first
            locked <= 1'b0;
        end else if (!locked) begin
            if (found) begin
                grant  <= next_grant;
                locked <= 1'b1;
            end
        end else if (m.tvalid && m.tready && m.tlast) begin
            locked <= 1'b0;                   // packet done, rearbitrate
        end
    end

    // forward only the owner, and only while locked
    assign m.tvalid   = locked & chan_tvalid[grant];
    assign m.tdata    = chan_tdata[grant];
    assign m.tlast    = chan_tlast[grant];
    assign grant_chan = grant;

    always_comb begin
        chan_tready = '0;
        if (locked) begin
            chan_tready[grant] = m.tready;   // others see tready low
        end
    end

endmodule

// ==== rtl/trigger_manager.sv ====
// fires the acquisition pulse to all channels, gathers their done flags and numbers each fill
module trigger_manager import wfd_pkg::*; (
    input  logic                clk125,
    input  logic                arst_n,
    input  logic                trigger,      // one cycle pulse
    input  logic [NUM_CHAN-1:0] chan_done,    // done pulses from the channels
    output logic [NUM_CHAN-1:0] acq_trigs,    // go pulse, one bit per channel
    output logic                fill_valid,   // towards the fill number fifo
    output fill_num_t           fill_num,
    input  logic                fill_ready
);

    tm_state_t           state;
    logic [NUM_CHAN-1:0] done_seen;   // sticky done flags of the running fill
    logic                all_done;

    // a done pulse landing in the same cycle still counts
    assign all_done = &(done_seen | chan_done);

    assign fill_valid = (state == TM_PUSH);   // fill_num is steady while pushing

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= TM_IDLE;
            acq_trigs <= '0;
            done_seen <= '0;
            fill_num  <= '0;                  // first fill comes out as 1
        end else begin
            acq_trigs <= '0;                  // go is only ever one cycle wide

            case (state)
                TM_IDLE: begin
                    if (trigger) begin
                        acq_trigs <= '1;              // all channels start together
                        done_seen <= '0;
                        fill_num  <= fill_num + 1'b1;
                        state     <= TM_WAIT_DONE;
                    end
                end

                // triggers in here are dropped on purpose
                TM_WAIT_DONE: begin
                    done_seen <= done_seen | chan_done;
                    if (all_done) begin
                        state <= TM_PUSH;
                    end
                end

                TM_PUSH: begin
                    if (fill_ready) begin             // stall while the fifo is full
                        state <= TM_IDLE;
                    end
                end

                default: state <= TM_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/wfd_pkg.sv ====
// shared widths, depths, daq tags and fsm state types, imported by every readout core module
package wfd_pkg;

    // channel side
    localparam int NUM_CHAN   = 2;                    // channel fpgas on the board
    localparam int CHAN_W     = 1;                    // bits to name one channel
    localparam int CHAN_DW    = 32;                   // channel stream payload width

    // fill numbering
    localparam int FILL_W          = 24;              // fill number width
    localparam int FILL_FIFO_DEPTH = 4;               // must stay a power of two
    localparam int FIFO_PTR_W      = $clog2(FILL_FIFO_DEPTH);

    // daq event words
    localparam int DAQ_DW      = 64;
    localparam int DAQ_CNT_W   = 32;                  // trailer word count field
    localparam logic [7:0] DAQ_HDR_TAG = 8'hA5;       // bits 63:56 of a header
    localparam logic [7:0] DAQ_TRL_TAG = 8'h5A;       // bits 63:56 of a trailer

    typedef logic [FILL_W-1:0]  fill_num_t;
    typedef logic [CHAN_DW-1:0] chan_word_t;
    typedef logic [DAQ_DW-1:0]  daq_word_t;

    // trigger manager
    typedef enum logic [1:0] {
        TM_IDLE,          // armed, waiting for a trigger
        TM_WAIT_DONE,     // acquisition running on the channels
        TM_PUSH           // handing the fill number to the fifo
    } tm_state_t;

    // data transfer manager
    typedef enum logic [2:0] {
        DTM_IDLE,         // waiting for a fill number
        DTM_HEADER,       // header word into the daq output register
        DTM_REQUEST,      // readout request to the current channel
        DTM_COLLECT,      // moving that channel's packet into the event
        DTM_TRAILER       // closing word with the data word count
    } dtm_state_t;

endpackage

// ==== rtl/wfd_top.sv ====
// top of the master board readout core, ties the trigger, fifo, arbiter and dtm to plain ports
module wfd_top import wfd_pkg::*; (
    input  logic                clk125,
    input  logic                arst_n,
    // triggering
    input  logic                trigger,
    output logic [NUM_CHAN-1:0] acq_trigs,    // go to the channel fpgas
    input  logic [NUM_CHAN-1:0] chan_done,
    // channel 0 rx stream
    input  logic                c0_rx_tvalid,
    input  chan_word_t          c0_rx_tdata,
    input  logic                c0_rx_tlast,
    output logic                c0_rx_tready,
    // channel 1 rx stream
    input  logic                c1_rx_tvalid,
    input  chan_word_t          c1_rx_tdata,
    input  logic                c1_rx_tlast,
    output logic                c1_rx_tready,
    // readout request towards the channel tx links
    output logic                req_valid,
    output logic [CHAN_W-1:0]   req_chan,     // routes the request
    output fill_num_t           req_fill,
    input  logic                req_ready,
    // amc13 daq link
    output logic                daq_valid,
    output logic                daq_header,
    output logic                daq_trailer,
    output daq_word_t           daq_data,
    input  logic                daq_ready
);

    // tm to fifo
    logic      tm_fill_valid;
    fill_num_t tm_fill_num;
    logic      tm_fill_ready;

    // fifo to dtm
    logic      fifo_fill_valid;
    fill_num_t fifo_fill_num;
    logic      fifo_fill_ready;

    // channel streams packed for the arbiter, bit n is channel n
    logic [NUM_CHAN-1:0]       rx_tvalid;
    chan_word_t [NUM_CHAN-1:0] rx_tdata;
    logic [NUM_CHAN-1:0]       rx_tlast;
    logic [NUM_CHAN-1:0]       rx_tready;
    logic [CHAN_W-1:0]         grant_chan;

    chan_stream_if rx_stream ();   // arbiter to dtm

    assign rx_tvalid    = {c1_rx_tvalid, c0_rx_tvalid};
    assign rx_tdata     = {c1_rx_tdata, c0_rx_tdata};
    assign rx_tlast     = {c1_rx_tlast, c0_rx_tlast};
    assign c0_rx_tready = rx_tready[0];
    assign c1_rx_tready = rx_tready[1];

    trigger_manager tm (
        .clk125     (clk125),
        .arst_n     (arst_n),
        .trigger    (trigger),
        .chan_done  (chan_done),
        .acq_trigs  (acq_trigs),
        .fill_valid (tm_fill_valid),
        .fill_num   (tm_fill_num),
        .fill_ready (tm_fill_ready)
    );

    fill_num_fifo fill_fifo (
        .clk125    (clk125),
        .arst_n    (arst_n),
        .in_valid  (tm_fill_valid),
        .in_data   (tm_fill_num),
        .in_ready  (tm_fill_ready),
        .out_valid (fifo_fill_valid),
        .out_data  (fifo_fill_num),
        .out_ready (fifo_fill_ready)
    );

    rx_arbiter rx_arb (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .chan_tvalid (rx_tvalid),
        .chan_tdata  (rx_tdata),
        .chan_tlast  (rx_tlast),
        .chan_tready (rx_tready),
        .grant_chan  (grant_chan),
        .m           (rx_stream.source)
    );

    data_transfer_manager dtm (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .fill_valid  (fifo_fill_valid),
        .fill_num    (fifo_fill_num),
        .fill_ready  (fifo_fill_ready),
        .req_valid   (req_valid),
        .req_chan    (req_chan),
        .req_fill    (req_fill),
        .req_ready   (req_ready),
        .s           (rx_stream.sink),
        .grant_chan  (grant_chan),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data),
        .daq_ready   (daq_ready)
    );

endmodule

// ==== testbench/tb_wfd.sv ====
// testbench for the readout core, runs each stim file line as a test and checks the daq events
module tb_wfd import wfd_pkg::*; ();

    localparam logic [31:0] LFSR_SEED  = 32'h6f89;
    localparam int          DONE_DELAY = 5;       // cycles from go to done
    localparam int          WAIT_LIMIT = 2000;    // timeout of every wait loop, in cycles

    logic                  clk125 = 1'b0;
    logic                  arst_n = 1'b0;
    logic                  trigger = 1'b0;
    logic [NUM_CHAN-1:0]   chan_done = '0;
    logic [NUM_CHAN-1:0]   acq_trigs;
    logic [NUM_CHAN-1:0]   rx_tvalid = '0;
    logic [NUM_CHAN-1:0]   rx_tlast = '0;
    logic [NUM_CHAN-1:0]   rx_tready;
    chan_word_t            rx_tdata [NUM_CHAN] = '{default: '0};
    logic                  req_valid;
    logic [CHAN_W-1:0]     req_chan;
    fill_num_t             req_fill;
    logic                  req_ready = 1'b1;   // channels always take a request
    logic                  daq_valid, daq_header, daq_trailer;
    daq_word_t             daq_data;
    logic                  daq_ready = 1'b0;

    logic [31:0] pay_lfsr = LFSR_SEED;     // payload source
    logic [31:0] rdy_lfsr = LFSR_SEED;     // daq_ready toggling source
    logic        stall_en = 1'b0;
    int          errors = 0;
    int          acq_seen = 0, done_seen = 0, trailer_seen = 0;
    int          cur_words [NUM_CHAN];
    string       cur_name;                 // test now running
    chan_word_t  pay_q [NUM_CHAN][$];      // payloads the channel models still owe
    fill_num_t   req_fill_q[$];            // fill of each readout request still to come
    int          req_chan_q[$];            // channel of each readout request, in order
    daq_word_t   exp_q[$], rcv_q[$];
    logic [1:0]  exp_kind[$], rcv_kind[$]; // {header, trailer}

    wfd_top dut0 (
        .clk125 (clk125), .arst_n (arst_n), .trigger (trigger),
        .acq_trigs (acq_trigs), .chan_done (chan_done),
        .c0_rx_tvalid (rx_tvalid[0]), .c0_rx_tdata (rx_tdata[0]),
        .c0_rx_tlast (rx_tlast[0]), .c0_rx_tready (rx_tready[0]),
        .c1_rx_tvalid (rx_tvalid[1]), .c1_rx_tdata (rx_tdata[1]),
        .c1_rx_tlast (rx_tlast[1]), .c1_rx_tready (rx_tready[1]),
        .req_valid (req_valid), .req_chan (req_chan), .req_fill (req_fill),
        .req_ready (req_ready), .daq_valid (daq_valid), .daq_header (daq_header),
        .daq_trailer (daq_trailer), .daq_data (daq_data), .daq_ready (daq_ready)
    );

    initial begin
        forever #10 clk125 = ~clk125;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output chan_word_t w);
        for (int b = 0; b < 32; b++) begin
            pay_lfsr = lfsr_next(pay_lfsr);   // one step per bit
            w[b]     = pay_lfsr[0];
        end
    endtask

    task automatic check_daq(input string what, input daq_word_t exp, input daq_word_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h actual %h", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_fill(input string what, input fill_num_t exp, input fill_num_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %0d actual %0d", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("mismatch %s: expected %0d actual %0d", what, exp, act);
            errors++;
        end
    endtask

    task automatic pulse_trigger();
        @(negedge clk125);
        trigger = 1'b1;
        @(negedge clk125);
        trigger = 1'b0;
    endtask

    // daq sink, ready random only in stall tests
    always @(negedge clk125) begin
        if (stall_en) begin
            rdy_lfsr  = lfsr_next(rdy_lfsr);
            daq_ready = rdy_lfsr[0];
        end else begin
            daq_ready = arst_n;
        end
    end

    always @(posedge clk125) begin
        if (arst_n && daq_valid && daq_ready) begin
            rcv_q.push_back(daq_data);
            rcv_kind.push_back({daq_header, daq_trailer});
            if (daq_trailer) trailer_seen++;
        end
        if (arst_n && acq_trigs != '0) begin
            if (acq_trigs != '1) begin
                $display("acq_trigs pulse did not reach every channel");
                errors++;
            end
            acq_seen++;
        end
    end

    // all channels finish together a few cycles after go
    initial begin : done_model
        forever begin
            @(posedge clk125);
            if (acq_trigs != '0) begin
                repeat (DONE_DELAY) @(negedge clk125);
                chan_done = '1;
                @(negedge clk125);
                chan_done = '0;
                done_seen++;
            end
        end
    end

    // answers each readout request with the owed payload words
    initial begin : chan_model
        int         ch;
        int         t;
        chan_word_t w;
        forever begin
            @(posedge clk125);
            if (arst_n && req_valid && req_ready) begin
                ch = int'(req_chan);
                // requests go to channel 0 then 1, carrying the fill being read out
                if (req_chan_q.size() == 0) begin
                    $display("%s: readout request for channel %0d that no fill needs",
                             cur_name, ch);
                    errors++;
                end else begin
                    check_count({cur_name, " request channel"}, req_chan_q.pop_front(), ch);
                    check_fill({cur_name, " request fill"}, req_fill_q.pop_front(), req_fill);
                end
                for (int i = 0; i < cur_words[ch]; i++) begin
                    @(negedge clk125);
                    w = '0;
                    if (pay_q[ch].size() > 0) w = pay_q[ch].pop_front();
                    else begin
                        $display("channel %0d got a request with no payload left", ch);
                        errors++;
                    end
                    rx_tvalid[ch] = 1'b1;
                    rx_tdata[ch]  = w;
                    rx_tlast[ch]  = (i == cur_words[ch] - 1);
                    t = 0;
                    do begin
                        @(posedge clk125);
                        t++;
                    end while (!rx_tready[ch] && t < WAIT_LIMIT);
                    if (!rx_tready[ch]) begin
                        $display("channel %0d word was never accepted", ch);
                        errors++;
                    end
                end
                @(negedge clk125);
                rx_tvalid[ch] = 1'b0;
                rx_tlast[ch]  = 1'b0;
            end
        end
    end

    task automatic run_test(input string name, input int w0, input int w1, input int stall,
                            input int mode, input int first_fill, output bit timed_out);
        int         nfills, t, hf, acq_base, trl_base, done_base;
        chan_word_t w;
        nfills    = (mode == 2) ? 2 : 1;
        timed_out = 1'b0;
        cur_name  = name;
        cur_words[0] = w0;
        cur_words[1] = w1;
        exp_q.delete();
        exp_kind.delete();
        rcv_q.delete();
        rcv_kind.delete();
        req_chan_q.delete();
        req_fill_q.delete();
        // expected events straight from the event format
        for (int f = 0; f < nfills; f++) begin
            exp_q.push_back({DAQ_HDR_TAG, 32'd0, fill_num_t'(first_fill + f)});
            exp_kind.push_back(2'b10);
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                req_chan_q.push_back(ch);
                req_fill_q.push_back(fill_num_t'(first_fill + f));
                for (int i = 0; i < cur_words[ch]; i++) begin
                    draw_word(w);
                    pay_q[ch].push_back(w);
                    exp_q.push_back({24'd0, 8'(ch), w});   // channel field in 39:32
                    exp_kind.push_back(2'b00);
                end
            end
            exp_q.push_back({DAQ_TRL_TAG, 24'd0, 32'(w0 + w1)});
            exp_kind.push_back(2'b01);
        end
        stall_en  = (stall != 0);
        acq_base  = acq_seen;
        trl_base  = trailer_seen;
        done_base = done_seen;
        pulse_trigger();
        if (mode == 1) begin
            repeat (2) @(negedge clk125);
            pulse_trigger();                  // done still outstanding, must be ignored
        end
        if (mode == 2) begin
            t = 0;
            while (done_seen == done_base && t < WAIT_LIMIT) begin
                @(negedge clk125);
                t++;
            end
            if (done_seen == done_base) begin
                $display("%s: done pulse of the first fill never came", name);
                errors++;
                timed_out = 1'b1;
            end
            repeat (2) @(negedge clk125);     // push has left the trigger manager
            pulse_trigger();
        end
        t = 0;
        while (trailer_seen - trl_base < nfills && t < WAIT_LIMIT) begin
            @(negedge clk125);
            t++;
        end
        if (trailer_seen - trl_base < nfills) begin
            $display("%s: event trailer never arrived", name);
            errors++;
            timed_out = 1'b1;
        end
        repeat (30) @(negedge clk125);        // room for any extra event to show up
        stall_en = 1'b0;
        check_count({name, " acq pulses"}, nfills, acq_seen - acq_base);
        check_count({name, " event words"}, exp_q.size(), rcv_q.size());
        check_count({name, " unsent payload"}, 0, pay_q[0].size() + pay_q[1].size());
        check_count({name, " missing requests"}, 0, req_chan_q.size());
        hf = 0;
        for (int i = 0; i < exp_q.size() && i < rcv_q.size(); i++) begin
            check_daq($sformatf("%s word %0d", name, i), exp_q[i], rcv_q[i]);
            if (exp_kind[i] != rcv_kind[i]) begin
                $display("mismatch %s word %0d flags: expected %b actual %b",
                         name, i, exp_kind[i], rcv_kind[i]);
                errors++;
            end
            if (rcv_kind[i] == 2'b10) begin
                check_fill({name, " header fill"}, fill_num_t'(first_fill + hf),
                           rcv_q[i][FILL_W-1:0]);
                hf++;
            end
        end
        pay_q[0].delete();
        pay_q[1].delete();
        req_chan_q.delete();
        req_fill_q.delete();
    endtask

    initial begin : main
        int    fd, code, w0, w1, stall, mode, next_fill, err_before;
        int    tests_run, tests_failed;
        string line, name;
        bit    timed_out;
        next_fill    = 1;                     // first fill after reset is 1
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (4) @(negedge clk125);
        arst_n = 1'b1;
        fd = $fopen("testbench/wfd_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.substr(0, 0) == "#") continue;
                code = $sscanf(line, "%s %d %d %d %d", name, w0, w1, stall, mode);
                if (code != 5 || w0 < 1 || w1 < 1) begin
                    $display("malformed stimulus line skipped");
                    errors++;
                    continue;
                end
                err_before = errors;
                run_test(name, w0, w1, stall, mode, next_fill, timed_out);
                next_fill += (mode == 2) ? 2 : 1;
                tests_run++;
                if (errors == err_before) begin
                    $display("test %s passed", name);
                end else begin
                    $display("test %s failed with %0d errors", name, errors - err_before);
                    tests_failed++;
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/wfd_assert.sv ====
// concurrent checks on the readout core outputs, bound into every wfd_top instance
module wfd_assert import wfd_pkg::*; (
    input logic                clk125,
    input logic                arst_n,
    input logic [NUM_CHAN-1:0] acq_trigs,
    input logic                daq_valid,
    input logic                daq_ready,
    input logic                daq_header,
    input logic                daq_trailer,
    input daq_word_t           daq_data
);

    logic in_event;   // header moved, trailer still to come

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            in_event <= 1'b0;
        end else if (daq_valid && daq_ready) begin
            if (daq_header) in_event <= 1'b1;
            else if (daq_trailer) in_event <= 1'b0;
        end
    end

    // go is a single cycle pulse
    acq_one_cycle: assert property (@(posedge clk125) disable iff (!arst_n)
        (acq_trigs != '0) |=> (acq_trigs == '0))
        else $error("acq_trigs high for more than one cycle");

    // stalled daq word holds
    daq_hold: assert property (@(posedge clk125) disable iff (!arst_n)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_data)))
        else $error("daq word changed while stalled");

    trailer_after_header: assert property (@(posedge clk125) disable iff (!arst_n)
        (daq_valid && daq_trailer) |-> in_event)
        else $error("daq trailer without a header");

endmodule

bind wfd_top wfd_assert wfd_assert0 (.*);

// ==== testbench/wfd_stim.txt ====
# name words_ch0 words_ch1 daq_stall mode
# mode 0 single trigger, 1 extra trigger while done is pending, 2 two fills back to back
single_fill 4 3 0 0
one_word_each 1 1 0 0
long_ch0 12 2 0 0
long_ch1 2 12 0 0
stall_short 3 3 1 0
stall_long 9 7 1 0
extra_trigger 5 4 0 1
extra_trig_stall 3 6 1 1
back_to_back 8 8 0 2
back_to_back_stall 6 9 1 2
after_pipeline 4 5 0 0
